//--- frontend_top.f
frontend_pkg.sv
fetch_if.sv
pc_gen.sv
fetch_unit.sv
inst_decoder.sv
pkt_fifo.sv
release_ctrl.sv
frontend_top.sv
frontend_properties.sv
frontend_tb.sv

//--- Makefile
SRCS := $(shell cat frontend_top.f)

.PHONY: run clean

run: obj_dir/Vfrontend_tb
	@out="$$(./obj_dir/Vfrontend_tb)"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

obj_dir/Vfrontend_tb: frontend_top.f $(SRCS)
	verilator --binary --timing --assert --top-module frontend_tb -f frontend_top.f -o Vfrontend_tb

clean:
	rm -rf obj_dir

//--- frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb;
  import frontend_pkg::*;

  logic             clk;
  logic             rst_n;
  logic             imem_en_o;
  logic [31:0]      imem_addr_o;
  logic [63:0]      imem_rdata_i;
  logic             pkt_valid_o;
  logic             pkt_ready_i;
  fe_packet_t       pkt_o;
  logic             redirect_i;
  logic [31:0]      redirect_pc_i;
  logic             cfg_we_i;
  logic [CNT_W-1:0] cfg_batch_i;

  logic [63:0] imem [128];
  integer      seed;
  logic [31:0] exp_pc;
  int          pkt_count;
  int          queued;
  logic [2:0]  en_hist;
  int          batch_cfg;
  bit          seen_valid;
  bit          ready_random;
  bit          redirects_on;

  frontend_top i_frontend_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .imem_en_o     (imem_en_o),
    .imem_addr_o   (imem_addr_o),
    .imem_rdata_i  (imem_rdata_i),
    .pkt_valid_o   (pkt_valid_o),
    .pkt_ready_i   (pkt_ready_i),
    .pkt_o         (pkt_o),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_batch_i   (cfg_batch_i)
  );

  always #10 clk = ~clk;

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  // mostly defined ops, the rest keeps a random opcode
  function automatic logic [31:0] random_inst();
    logic [31:0] bits;
    int          pick;
    bits = $random(seed);
    pick = $unsigned($random(seed)) % 10;
    case (pick)
      0, 1: bits[31:26] = OP_ADD;
      2, 3: bits[31:26] = OP_ADDI;
      4:    bits[31:26] = OP_ST;
      5:    bits[31:26] = OP_BL;
      6, 7: bits[31:26] = OP_B;
      default: bits[31:26] = bits[31:26];
    endcase
    return bits;
  endfunction

  task automatic fill_memory();
    for (int a = 0; a < 128; a++)
      imem[a[6:0]] = {random_inst(), random_inst()};
  endtask

  // reference decode straight from the opcode table
  function automatic dec_inst_t ref_decode(logic [31:0] inst, logic [31:0] pc);
    dec_inst_t d;
    d    = '0;
    d.pc = pc;
    d.op = OP_ILL;
    case (inst[31:26])
      OP_ADD:
      begin
        d.op          = OP_ADD;
        d.ri.r_reg[0] = inst[14:10];
        d.ri.r_reg[1] = inst[9:5];
        d.ri.w_reg    = inst[4:0];
      end
      OP_ADDI:
      begin
        d.op          = OP_ADDI;
        d.ri.r_reg[1] = inst[9:5];
        d.ri.w_reg    = inst[4:0];
      end
      OP_ST:
      begin
        d.op          = OP_ST;
        d.ri.r_reg[0] = inst[4:0];
        d.ri.r_reg[1] = inst[9:5];
      end
      OP_BL:
      begin
        d.op       = OP_BL;
        d.ri.w_reg = 5'd1;
      end
      OP_B:
      begin
        d.op = OP_B;
      end
      default:
      begin
        d.op = OP_ILL;
      end
    endcase
    d.illegal = (d.op == OP_ILL);
    return d;
  endfunction

  function automatic fe_packet_t expected_packet(logic [31:0] pc);
    logic [63:0] grp;
    fe_packet_t  p;
    grp = imem[pc[9:3]];
    p   = '0;
    if (pc[2])
    begin
      // odd start, word 1 lands in slot 0
      p.mask    = 2'b01;
      p.inst[0] = ref_decode(grp[63:32], pc);
    end
    else
    begin
      p.mask    = 2'b11;
      p.inst[0] = ref_decode(grp[31:0], pc);
      p.inst[1] = ref_decode(grp[63:32], pc | 32'h4);
    end
    return p;
  endfunction

  function automatic logic [31:0] next_group_pc(logic [31:0] pc);
    return {pc[31:3] + 29'd1, 3'b000};
  endfunction

  task automatic check_mask(logic [1:0] exp_mask, logic [1:0] got_mask);
    if (got_mask !== exp_mask)
    begin
      $display("[ERROR] %0t ns pkt_o.mask expected %b got %b", $time, exp_mask, got_mask);
      abort_run("packet mask differs from the model");
    end
  endtask

  // only live slots are compared
  task automatic check_packet(fe_packet_t exp_pkt, fe_packet_t got_pkt);
    for (int i = 0; i < 2; i++)
    begin
      if (exp_pkt.mask[i[0]] && (got_pkt.inst[i[0]] !== exp_pkt.inst[i[0]]))
      begin
        $display("[ERROR] %0t ns pkt_o.inst[%0d] expected %h got %h", $time, i,
                 exp_pkt.inst[i[0]], got_pkt.inst[i[0]]);
        abort_run("decoded slot differs from the model");
      end
    end
  endtask

  // sample at the falling edge, drive 2 ns after the rising edge
  task automatic step_cycle();
    fe_packet_t  exp_pkt;
    logic        rd_pending;
    logic [31:0] rd_addr;
    @(negedge clk);
    if (pkt_valid_o && !seen_valid)
    begin
      seen_valid = 1'b1;
      if (batch_cfg == 4 && queued < 4)
        abort_run("packet released before four packets were queued");
    end
    // a fetch reaches the queue output three cycles after its read
    queued = queued + en_hist[2];
    if (batch_cfg == 0 && queued > 0 && !pkt_valid_o)
      abort_run("queued packet held back with batch set to zero");
    if (pkt_valid_o && pkt_ready_i)
    begin
      exp_pkt = expected_packet(exp_pc);
      check_mask(exp_pkt.mask, pkt_o.mask);
      check_packet(exp_pkt, pkt_o);
      exp_pc    = next_group_pc(exp_pc);
      pkt_count = pkt_count + 1;
      queued    = queued - 1;
    end
    rd_pending = imem_en_o;
    rd_addr    = imem_addr_o;
    en_hist    = {en_hist[1:0], imem_en_o};
    if (redirect_i)
    begin
      exp_pc     = redirect_pc_i;
      queued     = 0;
      en_hist    = '0;
      seen_valid = 1'b0;
    end
    @(posedge clk);
    #2;
    if (rd_pending)
      imem_rdata_i = imem[rd_addr[9:3]];
    pkt_ready_i   = ready_random ? ($unsigned($random(seed)) % 4 != 0) : 1'b1;
    redirect_i    = redirects_on && ($unsigned($random(seed)) % 40 == 0);
    redirect_pc_i = $random(seed) & 32'hffff_fffc;
  endtask

  task automatic write_batch(int n);
    cfg_we_i    = 1'b1;
    cfg_batch_i = CNT_W'(n);
    step_cycle();
    cfg_we_i  = 1'b0;
    batch_cfg = n;
  endtask

  task automatic run_packets(int target);
    int idle;
    int last;
    idle = 0;
    while (pkt_count < target)
    begin
      last = pkt_count;
      step_cycle();
      if (pkt_count == last)
        idle = idle + 1;
      else
        idle = 0;
      if (idle > 200)
        abort_run("no packet was accepted for 200 cycles");
    end
  endtask

  initial
  begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    imem_rdata_i  = '0;
    pkt_ready_i   = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    cfg_we_i      = 1'b0;
    cfg_batch_i   = '0;
    seed          = 32'hbaef_3d4d;
    exp_pc        = RESET_PC;
    pkt_count     = 0;
    queued        = 0;
    en_hist       = '0;
    batch_cfg     = 0;
    seen_valid    = 1'b0;
    ready_random  = 1'b0;
    redirects_on  = 1'b0;
    fill_memory();
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // batch of four, backend always ready
    write_batch(4);
    redirects_on = 1'b1;
    run_packets(150);
    // no gating, random back-pressure
    write_batch(0);
    ready_random = 1'b1;
    run_packets(400);
    $display("TEST OK");
    $finish;
  end

endmodule

//--- frontend_properties.sv
`timescale 1ns/1ps

module frontend_properties (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     imem_en_o,
  input logic                     pkt_valid_o,
  input logic                     pkt_ready_i,
  input frontend_pkg::fe_packet_t pkt_o,
  input logic                     redirect_i,
  input logic                     grp_valid_i,
  input logic                     grp_ready_i
);

  // queue is empty one edge into reset
  a_quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !pkt_valid_o)
    else $error("pkt_valid_o high during reset");

  a_pkt_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (pkt_valid_o && !pkt_ready_i && !redirect_i) |=> $stable(pkt_o))
    else $error("pkt_o changed while stalled");

  a_single_read: assert property (@(posedge clk) disable iff (!rst_n)
    imem_en_o |=> !imem_en_o)
    else $error("back-to-back imem reads");

  a_held_no_read: assert property (@(posedge clk) disable iff (!rst_n)
    (grp_valid_i && !grp_ready_i) |-> !imem_en_o)
    else $error("imem read while the group slot is held");

endmodule

bind frontend_top frontend_properties i_frontend_properties (
  .clk         (clk),
  .rst_n       (rst_n),
  .imem_en_o   (imem_en_o),
  .pkt_valid_o (pkt_valid_o),
  .pkt_ready_i (pkt_ready_i),
  .pkt_o       (pkt_o),
  .redirect_i  (redirect_i),
  .grp_valid_i (grp_valid),
  .grp_ready_i (grp_ready)
);

//--- frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
  input  logic                           clk,
  input  logic                           rst_n,
  output logic                           imem_en_o,
  output logic [31:0]                    imem_addr_o,
  input  logic [63:0]                    imem_rdata_i,
  output logic                           pkt_valid_o,
  input  logic                           pkt_ready_i,
  output frontend_pkg::fe_packet_t       pkt_o,
  input  logic                           redirect_i,
  input  logic [31:0]                    redirect_pc_i,
  input  logic                           cfg_we_i,
  input  logic [frontend_pkg::CNT_W-1:0] cfg_batch_i
);
  import frontend_pkg::*;

  fetch_if fetch_req ();

  fetch_group_t     grp;
  logic             grp_valid;
  logic             grp_ready;
  dec_inst_t [1:0]  dec;
  fe_packet_t       pkt_in;
  logic             fifo_valid;
  logic             fifo_ready;
  logic [CNT_W-1:0] fifo_count;

  pc_gen i_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .fetch_req     (fetch_req.gen)
  );

  fetch_unit i_fetch_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .redirect_i   (redirect_i),
    .fetch_req    (fetch_req.fetch),
    .imem_rdata_i (imem_rdata_i),
    .grp_ready_i  (grp_ready),
    .imem_en_o    (imem_en_o),
    .imem_addr_o  (imem_addr_o),
    .grp_valid_o  (grp_valid),
    .grp_o        (grp)
  );

  // slot 1 always sits at the odd word
  for (genvar i = 0; i < 2; i++)
  begin : g_dec
    inst_decoder i_inst_decoder (
      .inst_i (grp.inst[i]),
      .pc_i   ((i == 0) ? grp.pc : (grp.pc | 32'h4)),
      .dec_o  (dec[i])
    );
  end

  assign pkt_in.inst = dec;
  assign pkt_in.mask = grp.mask;

  pkt_fifo i_pkt_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (redirect_i),
    .push_valid_i (grp_valid),
    .push_i       (pkt_in),
    .pop_ready_i  (fifo_ready),
    .push_ready_o (grp_ready),
    .pop_valid_o  (fifo_valid),
    .pop_o        (pkt_o),
    .count_o      (fifo_count)
  );

  release_ctrl i_release_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .redirect_i   (redirect_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_batch_i  (cfg_batch_i),
    .count_i      (fifo_count),
    .fifo_valid_i (fifo_valid),
    .pkt_ready_i  (pkt_ready_i),
    .pkt_valid_o  (pkt_valid_o),
    .fifo_ready_o (fifo_ready)
  );

endmodule

//--- release_ctrl.sv
`timescale 1ns/1ps

module release_ctrl (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           redirect_i,
  input  logic                           cfg_we_i,
  input  logic [frontend_pkg::CNT_W-1:0] cfg_batch_i,
  input  logic [frontend_pkg::CNT_W-1:0] count_i,
  input  logic                           fifo_valid_i,
  input  logic                           pkt_ready_i,
  output logic                           pkt_valid_o,
  output logic                           fifo_ready_o
);
  import frontend_pkg::*;

  logic [CNT_W-1:0] batch_q;
  logic             open_q;
  logic             fill_ok;
  logic             gate;

  // batch never exceeds the depth so a full queue qualifies too
  assign fill_ok = (count_i != '0) && (count_i >= batch_q);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      batch_q <= '0;
      open_q  <= 1'b0;
    end
    else
    begin
      if (cfg_we_i)
        batch_q <= (cfg_batch_i > CNT_W'(FIFO_DEPTH)) ? CNT_W'(FIFO_DEPTH) : cfg_batch_i;
      if (redirect_i)
        open_q <= 1'b0;
      else if (open_q)
        open_q <= (count_i != '0);
      else
        open_q <= fill_ok;
    end
  end

  // zero batch means no gating at all
  assign gate         = open_q || (batch_q == '0);
  assign pkt_valid_o  = fifo_valid_i && gate;
  assign fifo_ready_o = pkt_ready_i && gate;

endmodule

//--- pkt_fifo.sv
`timescale 1ns/1ps

module pkt_fifo (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           flush_i,
  input  logic                           push_valid_i,
  input  frontend_pkg::fe_packet_t       push_i,
  input  logic                           pop_ready_i,
  output logic                           push_ready_o,
  output logic                           pop_valid_o,
  output frontend_pkg::fe_packet_t       pop_o,
  output logic [frontend_pkg::CNT_W-1:0] count_o
);
  import frontend_pkg::*;

  fe_packet_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign push_ready_o = (count_q != CNT_W'(FIFO_DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign push         = push_valid_i && push_ready_o;
  assign pop          = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr_q] <= push_i;
  end

  assign pop_o   = mem[rd_ptr_q];
  assign count_o = count_q;

endmodule

//--- inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
  input  logic [31:0]             inst_i,
  input  logic [31:0]             pc_i,
  output frontend_pkg::dec_inst_t dec_o
);
  import frontend_pkg::*;

  op_e     op;
  r0_sel_e r0_sel;
  r1_sel_e r1_sel;
  w_sel_e  w_sel;

  always_comb
  begin
    case (inst_i[31:26])
      OP_ADD:  op = OP_ADD;
      OP_ADDI: op = OP_ADDI;
      OP_ST:   op = OP_ST;
      OP_BL:   op = OP_BL;
      OP_B:    op = OP_B;
      default: op = OP_ILL;
    endcase
  end

  // register usage per opcode
  always_comb
  begin
    r0_sel = R0_NONE;
    r1_sel = R1_NONE;
    w_sel  = W_NONE;
    case (op)
      OP_ADD:
      begin
        r0_sel = R0_RK;
        r1_sel = R1_RJ;
        w_sel  = W_RD;
      end
      OP_ADDI:
      begin
        r1_sel = R1_RJ;
        w_sel  = W_RD;
      end
      OP_ST:
      begin
        r0_sel = R0_RD;
        r1_sel = R1_RJ;
      end
      OP_BL:
      begin
        // link register
        w_sel = W_BL1;
      end
      default:
      begin
        w_sel = W_NONE;
      end
    endcase
  end

  always_comb
  begin
    dec_o.pc      = pc_i;
    dec_o.op      = op;
    dec_o.illegal = (op == OP_ILL);
    case (r0_sel)
      R0_RK:   dec_o.ri.r_reg[0] = inst_i[14:10];
      R0_RD:   dec_o.ri.r_reg[0] = inst_i[4:0];
      default: dec_o.ri.r_reg[0] = 5'd0;
    endcase
    case (r1_sel)
      R1_RJ:   dec_o.ri.r_reg[1] = inst_i[9:5];
      default: dec_o.ri.r_reg[1] = 5'd0;
    endcase
    case (w_sel)
      W_RD:    dec_o.ri.w_reg = inst_i[4:0];
      W_BL1:   dec_o.ri.w_reg = 5'd1;
      default: dec_o.ri.w_reg = 5'd0;
    endcase
  end

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       redirect_i,
  fetch_if.fetch                     fetch_req,
  input  logic [63:0]                imem_rdata_i,
  input  logic                       grp_ready_i,
  output logic                       imem_en_o,
  output logic [31:0]                imem_addr_o,
  output logic                       grp_valid_o,
  output frontend_pkg::fetch_group_t grp_o
);
  import frontend_pkg::*;

  logic         pend_q;
  logic         grp_valid_q;
  logic [31:0]  req_pc_q;
  logic [1:0]   req_mask_q;
  fetch_group_t grp_q;
  fetch_group_t grp_d;
  logic         accept;

  // one read in flight, slot must be free when it lands
  assign fetch_req.ready = !redirect_i && !pend_q && (!grp_valid_q || grp_ready_i);
  assign accept          = fetch_req.valid && fetch_req.ready;

  assign imem_en_o   = accept;
  assign imem_addr_o = {fetch_req.pc[31:3], 3'b000};

  always_comb
  begin
    grp_d.pc   = req_pc_q;
    grp_d.inst = imem_rdata_i;
    grp_d.mask = req_mask_q;
    // shift word 1 down into slot 0
    if (!req_mask_q[0])
    begin
      grp_d.mask    = {1'b0, req_mask_q[1]};
      grp_d.inst[0] = imem_rdata_i[63:32];
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pend_q      <= 1'b0;
      grp_valid_q <= 1'b0;
    end
    else if (redirect_i)
    begin
      pend_q      <= 1'b0;
      grp_valid_q <= 1'b0;
    end
    else
    begin
      pend_q <= accept;
      if (pend_q)
        grp_valid_q <= 1'b1;
      else if (grp_ready_i)
        grp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      req_pc_q   <= fetch_req.pc;
      req_mask_q <= fetch_req.mask;
    end
    if (pend_q)
      grp_q <= grp_d;
  end

  assign grp_valid_o = grp_valid_q;
  assign grp_o       = grp_q;

endmodule

//--- pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        redirect_i,
  input  logic [31:0] redirect_pc_i,
  fetch_if.gen        fetch_req
);
  import frontend_pkg::*;

  logic [31:0] pc_q;
  logic        valid_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pc_q    <= RESET_PC;
      valid_q <= 1'b0;
    end
    else if (redirect_i)
    begin
      pc_q    <= redirect_pc_i;
      valid_q <= 1'b1;
    end
    else
    begin
      valid_q <= 1'b1;
      // next 8-byte group
      if (fetch_req.valid && fetch_req.ready)
        pc_q <= {pc_q[31:3] + 29'd1, 3'b000};
    end
  end

  assign fetch_req.valid = valid_q;
  assign fetch_req.pc    = pc_q;
  // odd word start, only the upper slot is live
  assign fetch_req.mask  = pc_q[2] ? 2'b10 : 2'b11;

endmodule

//--- fetch_if.sv
`timescale 1ns/1ps

interface fetch_if;

  logic        valid;
  logic        ready;
  logic [31:0] pc;
  // pre-alignment slot mask
  logic [1:0]  mask;

  modport gen (
    output valid,
    output pc,
    output mask,
    input  ready
  );

  modport fetch (
    input  valid,
    input  pc,
    input  mask,
    output ready
  );

endinterface

//--- frontend_pkg.sv
package frontend_pkg;

  localparam logic [31:0] RESET_PC = 32'h0000_0000;
  localparam int FIFO_DEPTH = 8;
  localparam int CNT_W = 4;
  localparam int PTR_W = $clog2(FIFO_DEPTH);

  // major opcode, inst[31:26]
  typedef enum logic [5:0] {
    OP_ADD  = 6'h01,
    OP_ADDI = 6'h02,
    OP_ST   = 6'h03,
    OP_BL   = 6'h04,
    OP_B    = 6'h05,
    OP_ILL  = 6'h3f
  } op_e;

  typedef enum logic [1:0] {
    R0_NONE,
    R0_RK,
    R0_RD
  } r0_sel_e;

  typedef enum logic {
    R1_NONE,
    R1_RJ
  } r1_sel_e;

  typedef enum logic [1:0] {
    W_NONE,
    W_RD,
    W_BL1
  } w_sel_e;

  typedef struct packed {
    logic [1:0][4:0] r_reg;
    logic [4:0]      w_reg;
  } reg_info_t;

  typedef struct packed {
    logic [31:0] pc;
    op_e         op;
    reg_info_t   ri;
    logic        illegal;
  } dec_inst_t;

  typedef struct packed {
    logic [31:0]      pc;
    logic [1:0][31:0] inst;
    logic [1:0]       mask;
  } fetch_group_t;

  typedef struct packed {
    dec_inst_t [1:0] inst;
    logic [1:0]      mask;
  } fe_packet_t;

endpackage
